//--- fb_pkg.sv
/*
 * Shared types and constants for the DDR-backed framebuffer.
 * Covers the memory command layout, the write chunk, the raster position,
 * the frame size and the conversion of a stored pixel to RGB888.
 * Modules pull it in with a wildcard import in their header.
 */
package fb_pkg;

    // one memory word holds four pixels, one per 32-bit lane
    localparam int PIX_LANE_BITS  = 32;
    localparam int CHUNK_PIXELS   = 4;
    localparam int MEM_DATA_BITS  = 128;
    localparam int MEM_ADDR_BITS  = 28;
    localparam int LINE_BUF_DEPTH = 32;

    // grey bars around the window
    localparam logic [23:0] BORDER_RGB = 24'h202020;

    // application port opcodes
    typedef enum logic [2:0] {
        MEM_WRITE = 3'd0,
        MEM_READ  = 3'd1
    } mem_op_e;

    typedef struct packed {
        mem_op_e                  op;
        logic [MEM_ADDR_BITS-1:0] addr;
        logic [MEM_DATA_BITS-1:0] wdata;
    } mem_cmd_t;

    typedef struct packed {
        logic [MEM_ADDR_BITS-1:0] addr;
        logic [MEM_DATA_BITS-1:0] data;
    } chunk_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic [10:0] cx;
        logic [9:0]  cy;
        logic        h_active;
        logic        v_active;
    } raster_pos_t;

    typedef struct packed {
        logic [10:0] width;
        logic [9:0]  height;
    } fb_size_t;

    // channels left-aligned, low bits zero
    function automatic rgb_t to_rgb(input logic [PIX_LANE_BITS-1:0] pixel,
                                    input int color_bits);
        rgb_t c;
        case (color_bits)
            12: c = {pixel[11:8], 4'b0, pixel[7:4], 4'b0, pixel[3:0], 4'b0};
            15: c = {pixel[14:10], 3'b0, pixel[9:5], 3'b0, pixel[4:0], 3'b0};
            18: c = {pixel[17:12], 2'b0, pixel[11:6], 2'b0, pixel[5:0], 2'b0};
            24: c = pixel[23:0];
            default: c = BORDER_RGB;
        endcase
        return c;
    endfunction

endpackage

//--- raster_timing.sv
`timescale 1ns/100ps
/*
 * Raster position counters for the video output.
 * cx steps once per clock and wraps at H_TOTAL, cy steps at each line end.
 * The active flags mark the visible part of the line and of the frame.
 */
module raster_timing
    import fb_pkg::*;
#(
    parameter int H_ACTIVE = 1280,
    parameter int H_TOTAL  = 1650,
    parameter int V_ACTIVE = 720,
    parameter int V_TOTAL  = 750
) (
    input  logic        clk_x1,
    input  logic        ddr_rst,
    output raster_pos_t pos
);

    logic [10:0] cx;
    logic [9:0]  cy;

    always_ff @(posedge clk_x1) begin
        if (ddr_rst) begin
            cx <= '0;
            cy <= '0;
        end else if (cx == 11'(H_TOTAL - 1)) begin
            cx <= '0;
            // frame wrap
            cy <= (cy == 10'(V_TOTAL - 1)) ? '0 : cy + 10'd1;
        end else begin
            cx <= cx + 11'd1;
        end
    end

    always_comb begin
        pos.cx       = cx;
        pos.cy       = cy;
        pos.h_active = (cx < 11'(H_ACTIVE));
        pos.v_active = (cy < 10'(V_ACTIVE));
    end

endmodule

//--- fb_pixel_writer.sv
`timescale 1ns/100ps
/*
 * Pixel input side of the framebuffer.
 * Tracks the write position against the run-time frame size, gathers four
 * pixels and hands each full chunk to the arbiter as a one-cycle strobe.
 * fb_vsync puts the position back to the top-left pixel.
 */
module fb_pixel_writer
    import fb_pkg::*;
#(
    parameter int WIDTH      = 640,
    parameter int COLOR_BITS = 18
) (
    input  logic                  clk_x1,
    input  logic                  ddr_rst,
    input  fb_size_t              fb_size,
    input  logic                  fb_vsync,
    input  logic                  fb_we,
    input  logic [COLOR_BITS-1:0] fb_data,
    output logic                  wr_stb,
    output chunk_t                wr_chunk
);

    logic [10:0]              col;
    logic [9:0]               row;
    logic [10:0]              col_next;
    logic [9:0]               row_next;
    logic [COLOR_BITS-1:0]    stage [CHUNK_PIXELS];
    logic [MEM_ADDR_BITS-1:0] chunk_addr;

    assign col_next = col + 11'd1;
    assign row_next = row + 10'd1;

    ////////////////////////////////////////////////////////////
    // write position

    always_ff @(posedge clk_x1) begin
        if (ddr_rst) begin
            col    <= '0;
            row    <= '0;
            wr_stb <= 1'b0;
        end else begin
            wr_stb <= 1'b0;
            if (fb_vsync) begin
                col <= '0;
                row <= '0;
            end else if (fb_we) begin
                if (col_next >= fb_size.width) begin
                    col <= '0;
                    row <= (row_next >= fb_size.height) ? '0 : row_next;
                end else begin
                    col <= col_next;
                end
                // fourth pixel of the chunk
                if (col[1:0] == 2'd3) begin
                    wr_stb <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // staging and chunk address

    always_ff @(posedge clk_x1) begin
        if (fb_we) begin
            stage[col[1:0]] <= fb_data;
            if (col[1:0] == 2'd3) begin
                chunk_addr <= MEM_ADDR_BITS'(row) * MEM_ADDR_BITS'(WIDTH)
                            + MEM_ADDR_BITS'({col[10:2], 2'b00});
            end
        end
    end

    // stage stays put during the strobe cycle, lanes zero-extended
    always_comb begin
        wr_chunk.addr = chunk_addr;
        wr_chunk.data = '0;
        for (int i = 0; i < CHUNK_PIXELS; i++) begin
            wr_chunk.data[i*PIX_LANE_BITS +: COLOR_BITS] = stage[i];
        end
    end

endmodule

//--- fb_mem_arbiter.sv
`timescale 1ns/100ps
/*
 * Command arbiter in front of the memory application port.
 * Holds one pending read and one pending write and issues them on cmd.
 * cmd_ready is sampled a cycle ahead, and cmd_en follows a ready cycle.
 * A pending read always goes before a pending write.
 */
module fb_mem_arbiter
    import fb_pkg::*;
(
    input  logic                     clk_x1,
    input  logic                     ddr_rst,
    input  logic                     wr_stb,
    input  chunk_t                   wr_chunk,
    input  logic                     rd_stb,
    input  logic [MEM_ADDR_BITS-1:0] rd_addr,
    input  logic                     cmd_ready,
    output logic                     cmd_en,
    output mem_cmd_t                 cmd
);

    logic                     rd_pend;
    logic                     wr_pend;
    logic [MEM_ADDR_BITS-1:0] rd_addr_q;
    chunk_t                   wr_q;
    logic                     issue_rd;
    logic                     issue_wr;

    // reads win
    assign issue_rd = cmd_ready && rd_pend;
    assign issue_wr = cmd_ready && wr_pend && !rd_pend;

    always_ff @(posedge clk_x1) begin
        if (ddr_rst) begin
            rd_pend <= 1'b0;
            wr_pend <= 1'b0;
            cmd_en  <= 1'b0;
        end else begin
            cmd_en <= issue_rd || issue_wr;
            if (issue_rd) begin
                rd_pend <= 1'b0;
            end
            if (issue_wr) begin
                wr_pend <= 1'b0;
            end
            // new requests land in empty slots
            if (rd_stb) begin
                rd_pend <= 1'b1;
            end
            if (wr_stb) begin
                wr_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_x1) begin
        if (rd_stb) begin
            rd_addr_q <= rd_addr;
        end
        if (wr_stb) begin
            wr_q <= wr_chunk;
        end
        if (issue_rd) begin
            cmd <= '{op: MEM_READ, addr: rd_addr_q, wdata: '0};
        end else if (issue_wr) begin
            cmd <= '{op: MEM_WRITE, addr: wr_q.addr, wdata: wr_q.data};
        end
    end

    // producers keep their strobes 4+ cycles apart so the slots are free
    a_rd_slot: assert property (@(posedge clk_x1) disable iff (ddr_rst) rd_stb |-> !rd_pend)
        else $error("read request dropped, slot still pending");
    a_wr_slot: assert property (@(posedge clk_x1) disable iff (ddr_rst) wr_stb |-> !wr_pend)
        else $error("write chunk dropped, slot still pending");

endmodule

//--- fb_prefetch.sv
`timescale 1ns/100ps
/*
 * Read scheduler for the line buffer.
 * Starts LEAD cycles before the display window and walks the source line at
 * the same fractional rate as the scaler, requesting one chunk per four
 * source columns. A vertical accumulator picks the source row of each line.
 */
module fb_prefetch
    import fb_pkg::*;
#(
    parameter int WIDTH      = 640,
    parameter int DISP_WIDTH = 960,
    parameter int H_ACTIVE   = 1280,
    parameter int V_ACTIVE   = 720
) (
    input  logic                     clk_x1,
    input  logic                     ddr_rst,
    input  raster_pos_t              pos,
    input  fb_size_t                 fb_size,
    output logic                     rd_stb,
    output logic [MEM_ADDR_BITS-1:0] rd_addr
);

    localparam int X_START  = (H_ACTIVE - DISP_WIDTH) / 2;
    // a full ring of source pixels, in display cycles
    localparam int LEAD     = LINE_BUF_DEPTH * DISP_WIDTH / WIDTH;
    localparam int PF_START = X_START - LEAD;

    if (X_START < LEAD) begin : g_lead_check
        $error("prefetch lead does not fit before the display window");
    end

    logic                     pf_run;
    logic [10:0]              pf_col;
    logic [11:0]              h_acc;
    logic [10:0]              v_acc;
    logic [MEM_ADDR_BITS-1:0] line_base;
    logic [11:0]              h_sum;
    logic [10:0]              v_sum;
    logic [10:0]              col_next;
    logic [10:0]              v_acc_next;
    logic [MEM_ADDR_BITS-1:0] base_next;
    logic                     line_start;
    logic                     step;
    logic                     chunk_req;

    assign line_start = pos.v_active && (pos.cx == 11'(PF_START));
    assign h_sum      = h_acc + 12'(fb_size.width);
    assign v_sum      = v_acc + 11'(fb_size.height);
    assign col_next   = pf_col + 11'd1;
    // source column moves on when the accumulator crosses DISP_WIDTH
    assign step       = pf_run && !line_start && (h_sum >= 12'(DISP_WIDTH));
    assign chunk_req  = step && (col_next[1:0] == 2'b00) && (col_next < fb_size.width);

    ////////////////////////////////////////////////////////////
    // source row for the coming line

    always_comb begin
        if (pos.cy == '0) begin
            v_acc_next = '0;
            base_next  = '0;
        end else if (v_sum >= 11'(V_ACTIVE)) begin
            v_acc_next = v_sum - 11'(V_ACTIVE);
            base_next  = line_base + MEM_ADDR_BITS'(WIDTH);
        end else begin
            v_acc_next = v_sum;
            base_next  = line_base;
        end
    end

    always_ff @(posedge clk_x1) begin
        if (ddr_rst) begin
            pf_run    <= 1'b0;
            rd_stb    <= 1'b0;
            pf_col    <= '0;
            h_acc     <= '0;
            v_acc     <= '0;
            line_base <= '0;
        end else begin
            rd_stb <= 1'b0;
            if (line_start) begin
                // chunk 0 right away
                pf_run    <= 1'b1;
                pf_col    <= '0;
                h_acc     <= '0;
                v_acc     <= v_acc_next;
                line_base <= base_next;
                rd_stb    <= 1'b1;
            end else if (pf_run) begin
                if (step) begin
                    h_acc  <= h_sum - 12'(DISP_WIDTH);
                    pf_col <= col_next;
                    rd_stb <= chunk_req;
                    if (col_next >= fb_size.width) begin
                        pf_run <= 1'b0;
                    end
                end else begin
                    h_acc <= h_sum;
                end
            end
        end
    end

    always_ff @(posedge clk_x1) begin
        if (line_start) begin
            rd_addr <= base_next;
        end else if (chunk_req) begin
            rd_addr <= line_base + MEM_ADDR_BITS'(col_next);
        end
    end

endmodule

//--- fb_line_buffer.sv
`timescale 1ns/100ps
/*
 * Ring of LINE_BUF_DEPTH source pixels between memory and scaler.
 * Each read word drops four pixels in at the fill pointer, which restarts
 * at the start of every line. The scaler reads one pixel combinationally.
 */
module fb_line_buffer
    import fb_pkg::*;
#(
    parameter int COLOR_BITS = 18
) (
    input  logic                              clk_x1,
    input  raster_pos_t                       pos,
    input  logic                              rd_valid,
    input  logic [MEM_DATA_BITS-1:0]          rd_data,
    input  logic [$clog2(LINE_BUF_DEPTH)-1:0] rd_idx,
    output logic [COLOR_BITS-1:0]             rd_pixel
);

    localparam int IDX_BITS = $clog2(LINE_BUF_DEPTH);

    logic [COLOR_BITS-1:0] pixels [LINE_BUF_DEPTH];
    logic [IDX_BITS-1:0]   fill_ptr;
    logic [IDX_BITS-1:0]   wr_base;

    // slot of column c is c mod depth
    assign wr_base = (pos.cx == '0) ? '0 : fill_ptr;

    always_ff @(posedge clk_x1) begin
        if (rd_valid) begin
            for (int i = 0; i < CHUNK_PIXELS; i++) begin
                pixels[wr_base + IDX_BITS'(i)] <= rd_data[i*PIX_LANE_BITS +: COLOR_BITS];
            end
            fill_ptr <= wr_base + IDX_BITS'(CHUNK_PIXELS);
        end else if (pos.cx == '0) begin
            fill_ptr <= '0;
        end
    end

    assign rd_pixel = pixels[rd_idx];

endmodule

//--- fb_scaler.sv
`timescale 1ns/100ps
/*
 * Upscaler and colour stage of the video output.
 * Display column k of the centred window shows source column
 * floor(k * width / DISP_WIDTH), rows follow the same rule against V_ACTIVE.
 * rgb and out_pos trail the raster position by one cycle.
 */
module fb_scaler
    import fb_pkg::*;
#(
    parameter int COLOR_BITS = 18,
    parameter int DISP_WIDTH = 960,
    parameter int H_ACTIVE   = 1280,
    parameter int V_ACTIVE   = 720
) (
    input  logic                              clk_x1,
    input  logic                              ddr_rst,
    input  raster_pos_t                       pos,
    input  fb_size_t                          fb_size,
    output logic [$clog2(LINE_BUF_DEPTH)-1:0] rd_idx,
    input  logic [COLOR_BITS-1:0]             rd_pixel,
    output rgb_t                              rgb,
    output raster_pos_t                       out_pos
);

    localparam int X_START  = (H_ACTIVE - DISP_WIDTH) / 2;
    localparam int X_END    = X_START + DISP_WIDTH;
    localparam int IDX_BITS = $clog2(LINE_BUF_DEPTH);

    logic [10:0] sx;
    logic [11:0] h_acc;
    logic [11:0] h_sum;
    logic [9:0]  sy;
    logic [10:0] v_acc;
    logic [10:0] v_sum;
    logic        win_x;
    logic        in_win;

    assign h_sum  = h_acc + 12'(fb_size.width);
    assign v_sum  = v_acc + 11'(fb_size.height);
    assign win_x  = (pos.cx >= 11'(X_START)) && (pos.cx < 11'(X_END));
    // rows past the frame height show border
    assign in_win = win_x && pos.h_active && pos.v_active && (sy < fb_size.height);
    assign rd_idx = sx[IDX_BITS-1:0];

    always_ff @(posedge clk_x1) begin
        if (ddr_rst) begin
            sx      <= '0;
            h_acc   <= '0;
            sy      <= '0;
            v_acc   <= '0;
            rgb     <= BORDER_RGB;
            out_pos <= '0;
        end else begin
            // column stepping inside the window, parked at zero outside
            if (!win_x) begin
                sx    <= '0;
                h_acc <= '0;
            end else if (h_sum >= 12'(DISP_WIDTH)) begin
                sx    <= sx + 11'd1;
                h_acc <= h_sum - 12'(DISP_WIDTH);
            end else begin
                h_acc <= h_sum;
            end

            // row step once per active line
            if (pos.cx == '0 && pos.v_active) begin
                if (pos.cy == '0) begin
                    sy    <= '0;
                    v_acc <= '0;
                end else if (v_sum >= 11'(V_ACTIVE)) begin
                    sy    <= sy + 10'd1;
                    v_acc <= v_sum - 11'(V_ACTIVE);
                end else begin
                    v_acc <= v_sum;
                end
            end

            rgb     <= in_win ? to_rgb(PIX_LANE_BITS'(rd_pixel), COLOR_BITS)
                              : rgb_t'(BORDER_RGB);
            out_pos <= pos;
        end
    end

endmodule

//--- ddr3_framebuffer.sv
`timescale 1ns/100ps
/*
 * Top level of the DDR-backed framebuffer core.
 * Pixels come in on fb_we/fb_data, go to memory in four-pixel chunks, are
 * read back ahead of the raster and shown upscaled in a centred window.
 * Ends at the memory application port and a parallel RGB output.
 */
module ddr3_framebuffer
    import fb_pkg::*;
#(
    parameter int WIDTH      = 640,
    parameter int HEIGHT     = 480,
    parameter int COLOR_BITS = 18,
    parameter int DISP_WIDTH = 960,
    parameter int H_ACTIVE   = 1280,
    parameter int H_TOTAL    = 1650,
    parameter int V_ACTIVE   = 720,
    parameter int V_TOTAL    = 750
) (
    input  logic                     clk_x1,
    input  logic                     ddr_rst,
    input  fb_size_t                 fb_size,
    input  logic                     fb_vsync,
    input  logic                     fb_we,
    input  logic [COLOR_BITS-1:0]    fb_data,
    input  logic                     cmd_ready,
    output logic                     cmd_en,
    output mem_cmd_t                 cmd,
    input  logic                     rd_valid,
    input  logic [MEM_DATA_BITS-1:0] rd_data,
    output rgb_t                     rgb,
    output raster_pos_t              out_pos
);

    raster_pos_t                       pos;
    logic                              wr_stb;
    chunk_t                            wr_chunk;
    logic                              rd_stb;
    logic [MEM_ADDR_BITS-1:0]          rd_addr;
    logic [$clog2(LINE_BUF_DEPTH)-1:0] rd_idx;
    logic [COLOR_BITS-1:0]             rd_pixel;

    ////////////////////////////////////////////////////////////
    // write path

    fb_pixel_writer #(.WIDTH(WIDTH), .COLOR_BITS(COLOR_BITS)) i_pixel_writer (
        .clk_x1, .ddr_rst, .fb_size, .fb_vsync, .fb_we, .fb_data,
        .wr_stb, .wr_chunk
    );

    fb_mem_arbiter i_mem_arbiter (
        .clk_x1, .ddr_rst, .wr_stb, .wr_chunk, .rd_stb, .rd_addr,
        .cmd_ready, .cmd_en, .cmd
    );

    ////////////////////////////////////////////////////////////
    // display path

    raster_timing #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
    ) i_raster_timing (
        .clk_x1, .ddr_rst, .pos
    );

    fb_prefetch #(
        .WIDTH(WIDTH), .DISP_WIDTH(DISP_WIDTH), .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
    ) i_prefetch (
        .clk_x1, .ddr_rst, .pos, .fb_size, .rd_stb, .rd_addr
    );

    fb_line_buffer #(.COLOR_BITS(COLOR_BITS)) i_line_buffer (
        .clk_x1, .pos, .rd_valid, .rd_data, .rd_idx, .rd_pixel
    );

    fb_scaler #(
        .COLOR_BITS(COLOR_BITS), .DISP_WIDTH(DISP_WIDTH),
        .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
    ) i_scaler (
        .clk_x1, .ddr_rst, .pos, .fb_size, .rd_idx, .rd_pixel, .rgb, .out_pos
    );

    // writer and prefetch addresses assume the frame fits the memory rows
    a_fb_size: assert property (@(posedge clk_x1) disable iff (ddr_rst)
                                fb_we |-> (fb_size.width <= 11'(WIDTH))
                                       && (fb_size.height <= 10'(HEIGHT)))
        else $error("frame size exceeds the WIDTH x HEIGHT memory area");

endmodule

//--- tb_mem_model.sv
`timescale 1ns/100ps
/*
 * Behavioural memory behind the application port, for the testbench only.
 * cmd_ready stalls at random, reads return in issue order after a fixed
 * latency, and accepted writes are logged in wr_count for the testbench.
 */
module tb_mem_model
    import fb_pkg::*;
#(
    parameter int          READ_LATENCY = 6,
    parameter int          DEPTH        = 256,
    parameter logic [31:0] SEED         = 32'h45133b81
) (
    input  logic                     clk_x1,
    input  logic                     ddr_rst,
    input  logic                     cmd_en,
    input  mem_cmd_t                 cmd,
    output logic                     cmd_ready,
    output logic                     rd_valid,
    output logic [MEM_DATA_BITS-1:0] rd_data,
    output int                       wr_count,
    output int                       port_errors
);

    localparam int AW = $clog2(DEPTH);

    logic [MEM_DATA_BITS-1:0] mem [DEPTH];
    logic                     pipe_valid [READ_LATENCY];
    logic [MEM_DATA_BITS-1:0] pipe_data [READ_LATENCY];

    initial begin
        integer                   seed;
        logic                     ready_prev;
        logic                     rd_hit;
        logic [MEM_DATA_BITS-1:0] rdata;
        seed        = SEED;
        ready_prev  = 1'b0;
        cmd_ready   = 1'b0;
        rd_valid    = 1'b0;
        rd_data     = '0;
        wr_count    = 0;
        port_errors = 0;
        // background words carry their own address
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = {4{32'h5a00_0000 | 32'(a)}};
        end
        for (int i = 0; i < READ_LATENCY; i++) begin
            pipe_valid[i] = 1'b0;
            pipe_data[i]  = '0;
        end
        forever begin
            @(posedge clk_x1);
            rd_hit = 1'b0;
            rdata  = '0;
            if (cmd_en === 1'b1 && !ddr_rst) begin
                // ready of the previous cycle grants this one
                if (!ready_prev) begin
                    port_errors++;
                    $display("cmd_en at %0t came after a cycle with cmd_ready low", $time);
                end
                if (cmd.addr >= MEM_ADDR_BITS'(DEPTH) || cmd.addr[1:0] != 2'b00) begin
                    port_errors++;
                    $display("command at %0t has a bad chunk address %h", $time, cmd.addr);
                end else if (cmd.op == MEM_WRITE) begin
                    mem[cmd.addr[AW-1:0]] = cmd.wdata;
                    wr_count++;
                end else begin
                    rd_hit = 1'b1;
                    rdata  = mem[cmd.addr[AW-1:0]];
                end
            end
            ready_prev = cmd_ready;
            #1;
            // read return pipe, in order
            for (int i = READ_LATENCY - 1; i > 0; i--) begin
                pipe_valid[i] = pipe_valid[i-1];
                pipe_data[i]  = pipe_data[i-1];
            end
            pipe_valid[0] = rd_hit;
            pipe_data[0]  = rdata;
            rd_valid      = pipe_valid[READ_LATENCY-1];
            rd_data       = pipe_data[READ_LATENCY-1];
            // roughly one stall in four
            cmd_ready = (($random(seed) & 3) != 0);
        end
    end

endmodule

//--- tb_ddr3_framebuffer.sv
`timescale 1ns/100ps
/*
 * Testbench for the framebuffer core.
 * Each line of fb_tests.txt gives a frame size and a pixel ramp. The frame
 * is written, the packed words are checked in the memory model, and then
 * one full displayed frame is checked pixel by pixel against the scaling rule
 * while the same frame is written again.
 */
module tb_ddr3_framebuffer
    import fb_pkg::*;
();

    localparam int WIDTH      = 32;
    localparam int HEIGHT     = 8;
    localparam int DISP_WIDTH = 64;
    localparam int H_ACTIVE   = 192;
    localparam int H_TOTAL    = 220;
    localparam int V_ACTIVE   = 16;
    localparam int V_TOTAL    = 20;
    localparam int COLOR_BITS = 18;
    localparam int X_START    = (H_ACTIVE - DISP_WIDTH) / 2;
    localparam int FRAME_CYC  = H_TOTAL * V_TOTAL;
    localparam int MAX_TESTS  = 16;

    logic                     clk_x1 = 1'b0;
    logic                     ddr_rst;
    fb_size_t                 fb_size;
    logic                     fb_vsync;
    logic                     fb_we;
    logic [COLOR_BITS-1:0]    fb_data;
    logic                     cmd_ready;
    logic                     cmd_en;
    mem_cmd_t                 cmd;
    logic                     rd_valid;
    logic [MEM_DATA_BITS-1:0] rd_data;
    rgb_t                     rgb;
    raster_pos_t              out_pos;
    int                       wr_count;
    int                       port_errors;

    int          mem_errors;
    int          video_errors;
    int          expected_writes;
    bit          timed_out;
    logic [31:0] test_words [4*MAX_TESTS];

    always #5 clk_x1 = ~clk_x1;

    ddr3_framebuffer #(
        .WIDTH(WIDTH), .HEIGHT(HEIGHT), .COLOR_BITS(COLOR_BITS), .DISP_WIDTH(DISP_WIDTH),
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
    ) i_ddr3_framebuffer (
        .clk_x1, .ddr_rst, .fb_size, .fb_vsync, .fb_we, .fb_data,
        .cmd_ready, .cmd_en, .cmd, .rd_valid, .rd_data, .rgb, .out_pos
    );

    tb_mem_model #(.READ_LATENCY(6), .DEPTH(256), .SEED(32'h45133b81)) i_mem_model (
        .clk_x1, .ddr_rst, .cmd_en, .cmd, .cmd_ready, .rd_valid, .rd_data,
        .wr_count, .port_errors
    );

    // pixel i of a frame is a ramp cut to the colour depth
    function automatic logic [COLOR_BITS-1:0] pixel_value(input int base, input int step,
                                                          input int idx);
        int v;
        v = base + step * idx;
        return v[COLOR_BITS-1:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus

    task automatic write_frame(input int w, input int h, input int base, input int step);
        @(posedge clk_x1);
        #1;
        fb_size  = '{width: 11'(w), height: 10'(h)};
        fb_vsync = 1'b1;
        @(posedge clk_x1);
        #1;
        fb_vsync = 1'b0;
        // one pixel every 4 cycles in raster order
        for (int i = 0; i < w * h; i++) begin
            @(posedge clk_x1);
            #1;
            fb_we   = 1'b1;
            fb_data = pixel_value(base, step, i);
            @(posedge clk_x1);
            #1;
            fb_we = 1'b0;
            repeat (2) @(posedge clk_x1);
        end
    endtask

    task automatic wait_writes(input int target);
        int n;
        n = 0;
        while (wr_count < target && !timed_out) begin
            @(negedge clk_x1);
            n++;
            if (n > 200) begin
                $display("timeout: only %0d of %0d memory writes were accepted",
                         wr_count, target);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        @(negedge clk_x1);
        while (!(out_pos.cx == '0 && out_pos.cy == '0) && !timed_out) begin
            @(negedge clk_x1);
            n++;
            if (n > FRAME_CYC + 10) begin
                $display("timeout: the video output never reached the start of a frame");
                timed_out = 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checks

    task automatic check_memory(input int w, input int h, input int base, input int step);
        int                       addr;
        logic [MEM_DATA_BITS-1:0] word;
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c += CHUNK_PIXELS) begin
                addr = r * WIDTH + c;
                word = '0;
                // lane j holds column c+j zero-extended
                for (int j = 0; j < CHUNK_PIXELS; j++) begin
                    word[j*PIX_LANE_BITS +: COLOR_BITS] = pixel_value(base, step, r * w + c + j);
                end
                if (i_mem_model.mem[addr] !== word) begin
                    mem_errors++;
                    $display("error at %0t: word %0d is %h, expected %h", $time, addr,
                             i_mem_model.mem[addr], word);
                end
            end
        end
    endtask

    // starts on the sample where out_pos is the frame origin
    task automatic check_frame(input int w, input int h, input int base, input int step);
        int                    cx;
        int                    cy;
        int                    sx;
        int                    sy;
        logic [COLOR_BITS-1:0] pix;
        logic [23:0]           exp_rgb;
        raster_pos_t           exp_pos;
        for (int n = 0; n < FRAME_CYC; n++) begin
            cx      = n % H_TOTAL;
            cy      = n / H_TOTAL;
            exp_pos = '{cx: 11'(cx), cy: 10'(cy), h_active: (cx < H_ACTIVE),
                        v_active: (cy < V_ACTIVE)};
            if (out_pos !== exp_pos) begin
                video_errors++;
                $display("error at %0t: out_pos is %0d,%0d h%0b v%0b, expected %0d,%0d h%0b v%0b",
                         $time, out_pos.cx, out_pos.cy, out_pos.h_active, out_pos.v_active,
                         cx, cy, exp_pos.h_active, exp_pos.v_active);
            end
            if (cx >= X_START && cx < X_START + DISP_WIDTH && cy < V_ACTIVE) begin
                sx      = (cx - X_START) * w / DISP_WIDTH;
                sy      = cy * h / V_ACTIVE;
                pix     = pixel_value(base, step, sy * w + sx);
                // 6 bits per channel left-aligned
                exp_rgb = {pix[17:12], 2'b00, pix[11:6], 2'b00, pix[5:0], 2'b00};
            end else begin
                exp_rgb = BORDER_RGB;
            end
            if (rgb !== exp_rgb) begin
                video_errors++;
                $display("error at %0t: rgb at %0d,%0d is %h, expected %h", $time, cx, cy,
                         rgb, exp_rgb);
            end
            @(negedge clk_x1);
        end
    endtask

    task automatic run_test(input int w, input int h, input int base, input int step);
        expected_writes += w * h / CHUNK_PIXELS;
        write_frame(w, h, base, step);
        wait_writes(expected_writes);
        if (timed_out) begin
            return;
        end
        check_memory(w, h, base, step);
        wait_frame_start();
        if (timed_out) begin
            return;
        end
        // same frame again while it is shown so writes compete with the reads
        expected_writes += w * h / CHUNK_PIXELS;
        fork
            check_frame(w, h, base, step);
            write_frame(w, h, base, step);
        join
        wait_writes(expected_writes);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int n_run;
        ddr_rst         = 1'b1;
        fb_size         = '0;
        fb_vsync        = 1'b0;
        fb_we           = 1'b0;
        fb_data         = '0;
        mem_errors      = 0;
        video_errors    = 0;
        expected_writes = 0;
        timed_out       = 1'b0;
        n_run           = 0;
        for (int i = 0; i < 4 * MAX_TESTS; i++) begin
            test_words[i] = '0;
        end
        $readmemh("fb_tests.txt", test_words);
        repeat (16) @(posedge clk_x1);
        #1;
        ddr_rst = 1'b0;
        // a zero width ends the table
        while (n_run < MAX_TESTS && test_words[4*n_run] != 0 && !timed_out) begin
            $display("frame %0d: %0dx%0d, base %h, step %h", n_run, test_words[4*n_run],
                     test_words[4*n_run+1], test_words[4*n_run+2], test_words[4*n_run+3]);
            run_test(test_words[4*n_run], test_words[4*n_run+1], test_words[4*n_run+2],
                     test_words[4*n_run+3]);
            n_run++;
        end
        if (n_run == 0) begin
            $display("no test frames could be read from fb_tests.txt");
        end
        $display("errors: memory %0d, video %0d, port %0d", mem_errors, video_errors,
                 port_errors);
        if (n_run > 0 && !timed_out && mem_errors + video_errors + port_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- fb_tests.txt
// one test frame per line, all values hex
// width  height  pixel_base  pixel_step
20 08 00100 00101
10 04 3f000 01234
20 08 12345 00777
08 02 2aaaa 0abcd
18 06 00000 00001
0c 03 15555 02468
1c 07 3ffff 3fff7
04 01 0f0f0 00111
20 08 20000 01001

//--- all.f
fb_pkg.sv
raster_timing.sv
fb_pixel_writer.sv
fb_mem_arbiter.sv
fb_prefetch.sv
fb_line_buffer.sv
fb_scaler.sv
ddr3_framebuffer.sv
tb_mem_model.sv
tb_ddr3_framebuffer.sv

//--- Makefile
# Verilator flow for the framebuffer testbench
TOP = tb_ddr3_framebuffer

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f *.sv
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

# a log without the closing report counts as a failure too
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
